/* design/aes_pkg.sv */
package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;

    ////////////////////////////////////////
    // round structure
    ////////////////////////////////////////

    parameter int NUM_ROUNDS    = 10;
    parameter int ROUND_LATENCY = 2;

    // one cycle of input whitening ahead of the rounds
    parameter int PIPE_LATENCY  = 1 + ROUND_LATENCY * NUM_ROUNDS;

    ////////////////////////////////////////
    // field constants
    ////////////////////////////////////////

    // low byte of x^8 + x^4 + x^3 + x + 1
    parameter byte_t GF_REDUCE = 8'h1b;

    parameter byte_t RCON [NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

endpackage

/* design/aes_sbox.sv */
`timescale 1ns/10ps

module aes_sbox (
    input  logic          clk,
    input  logic          en,
    input  aes_pkg::byte_t din,
    output aes_pkg::byte_t dout
);

    // bit 0 of x and s is the msb of the byte
    logic [0:7]  x;
    logic [0:7]  s;
    logic [21:0] y;
    logic [67:0] t;
    logic [17:0] z;

    always_comb
    begin
        x = din;

        ////////////////////////////////////////
        // top linear layer
        ////////////////////////////////////////
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9]  = x[0] ^ x[3];
        y[8]  = x[0] ^ x[5];
        t[0]  = x[1] ^ x[2];
        y[1]  = t[0] ^ x[7];
        y[4]  = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ x[0];
        y[5]  = y[1] ^ x[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6]  = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        ////////////////////////////////////////
        // nonlinear middle, the GF(2^4) inverse
        ////////////////////////////////////////
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & x[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];

        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];

        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];
        z[0]  = t[44] & y[15];
        z[1]  = t[37] & y[6];
        z[2]  = t[33] & x[7];
        z[3]  = t[43] & y[16];
        z[4]  = t[40] & y[1];
        z[5]  = t[29] & y[7];
        z[6]  = t[42] & y[11];
        z[7]  = t[45] & y[17];
        z[8]  = t[41] & y[10];
        z[9]  = t[44] & y[12];
        z[10] = t[37] & y[3];
        z[11] = t[33] & y[4];
        z[12] = t[43] & y[13];
        z[13] = t[40] & y[5];
        z[14] = t[29] & y[2];
        z[15] = t[42] & y[9];
        z[16] = t[45] & y[14];
        z[17] = t[41] & y[8];

        ////////////////////////////////////////
        // bottom linear layer with the affine constant
        ////////////////////////////////////////
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];
        s[0]  = t[59] ^ t[63];
        s[3]  = t[53] ^ t[66];
        s[4]  = t[51] ^ t[66];
        s[5]  = t[47] ^ t[65];
        s[6]  = ~t[56] ^ t[62];
        s[7]  = ~t[48] ^ t[60];
        s[1]  = ~t[64] ^ s[3];
        s[2]  = ~t[55] ^ t[67];
    end

    always_ff @(posedge clk)
        if (en)
            dout <= s;

endmodule

/* design/aes_column_lookup.sv */
`timescale 1ns/10ps

module aes_column_lookup (
    input  logic           clk,
    input  logic           en,
    input  aes_pkg::word_t column,
    output aes_pkg::word_t p0,
    output aes_pkg::word_t p1,
    output aes_pkg::word_t p2,
    output aes_pkg::word_t p3
);

    import aes_pkg::*;

    word_t lut [4];

    for (genvar i = 0; i < 4; i++)
    begin : g_byte
        byte_t sb;
        byte_t sb_x2;
        word_t t_word;

        aes_sbox u_sbox (
            .clk  (clk),
            .en   (en),
            .din  (column[31 - 8 * i -: 8]),
            .dout (sb)
        );

        // xtime on the registered S-box value
        assign sb_x2  = {sb[6:0], 1'b0} ^ (sb[7] ? GF_REDUCE : 8'h00);

        // layout is S, S, 3S, 2S from the top byte down
        assign t_word = {sb, sb, sb ^ sb_x2, sb_x2};

        // byte i lands in row i, so rotate right by one byte more per position
        assign lut[i] = word_t'({t_word, t_word} >> (8 * (i + 1)));
    end

    assign p0 = lut[0];
    assign p1 = lut[1];
    assign p2 = lut[2];
    assign p3 = lut[3];

endmodule

/* design/aes_key_stage.sv */
`timescale 1ns/10ps

module aes_key_stage #(
    parameter aes_pkg::byte_t RCON = 8'h01
) (
    input  logic            clk,
    input  logic            en,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t key_next,
    output aes_pkg::block_t round_key
);

    import aes_pkg::*;

    word_t w0;
    word_t w1;
    word_t w2;
    word_t w3;
    word_t v0;
    word_t rot_word;
    word_t pre0;
    word_t pre1;
    word_t pre2;
    word_t pre3;
    word_t sub_word;

    assign {w0, w1, w2, w3} = key_in;
    assign v0 = {w0[31:24] ^ RCON, w0[23:0]};

    // RotWord moves the top byte of the last word to the bottom
    assign rot_word = {w3[23:0], w3[31:24]};

    // prefix sums wait one cycle for the S-box path
    always_ff @(posedge clk)
        if (en)
            {pre0, pre1, pre2, pre3} <= {v0, v0 ^ w1, v0 ^ w1 ^ w2, v0 ^ w1 ^ w2 ^ w3};

    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk  (clk),
            .en   (en),
            .din  (rot_word[31 - 8 * i -: 8]),
            .dout (sub_word[31 - 8 * i -: 8])
        );
    end

    // the round that uses this key registers it in its second cycle
    assign round_key = {pre0 ^ sub_word, pre1 ^ sub_word, pre2 ^ sub_word, pre3 ^ sub_word};

    always_ff @(posedge clk)
        if (en)
            key_next <= round_key;

endmodule

/* design/aes_round.sv */
`timescale 1ns/10ps

module aes_round (
    input  logic            clk,
    input  logic            en,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    import aes_pkg::*;

    // lut[i][r] is the T-table word of row r from input column i
    word_t  lut [4][4];
    block_t mixed;

    for (genvar i = 0; i < 4; i++)
    begin : g_col
        aes_column_lookup u_lookup (
            .clk    (clk),
            .en     (en),
            .column (state_in[127 - 32 * i -: 32]),
            .p0     (lut[i][0]),
            .p1     (lut[i][1]),
            .p2     (lut[i][2]),
            .p3     (lut[i][3])
        );
    end

    // ShiftRows picks the diagonal, MixColumns is folded into the tables
    always_comb
    begin
        mixed = round_key;
        for (int c = 0; c < 4; c++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                mixed[127 - 32 * c -: 32] = mixed[127 - 32 * c -: 32] ^ lut[i][(i + 4 - c) % 4];
            end
        end
    end

    always_ff @(posedge clk)
        if (en)
            state_out <= mixed;

endmodule

/* design/aes_final_round.sv */
`timescale 1ns/10ps

module aes_final_round (
    input  logic            clk,
    input  logic            en,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    import aes_pkg::*;

    block_t shifted;

    ////////////////////////////////////////
    // SubBytes with ShiftRows in the wiring
    ////////////////////////////////////////

    // output byte n sits in column n/4, row n%4 and takes its row from column n/4 + n%4
    for (genvar n = 0; n < 16; n++)
    begin : g_byte
        localparam int SRC = 4 * (((n / 4) + (n % 4)) % 4) + (n % 4);

        aes_sbox u_sbox (
            .clk  (clk),
            .en   (en),
            .din  (state_in[127 - 8 * SRC -: 8]),
            .dout (shifted[127 - 8 * n -: 8])
        );
    end

    // no MixColumns in the last round
    always_ff @(posedge clk)
        if (en)
            state_out <= shifted ^ round_key;

endmodule

/* design/aes128_core.sv */
`timescale 1ns/10ps

module aes128_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::block_t ciphertext
);

    import aes_pkg::*;

    logic                    advance;
    logic [PIPE_LATENCY-1:0] valid_q;
    block_t                  state_q [NUM_ROUNDS];
    block_t                  key_q [NUM_ROUNDS];
    block_t                  round_key [NUM_ROUNDS];

    ////////////////////////////////////////
    // handshake and valid pipeline
    ////////////////////////////////////////

    // the whole pipeline stalls only when a finished block is not taken
    assign advance   = !out_valid || out_ready;
    assign in_ready  = advance;
    assign out_valid = valid_q[PIPE_LATENCY-1];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid_q <= '0;
        else if (advance)
            valid_q <= {valid_q[PIPE_LATENCY-2:0], in_valid};
    end

    // input whitening, round key 0 is the cipher key itself
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            state_q[0] <= plaintext ^ key;
            key_q[0]   <= key;
        end
    end

    ////////////////////////////////////////
    // key schedule chain
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROUNDS; i++)
    begin : g_key
        if (i < NUM_ROUNDS - 1)
        begin : g_link
            aes_key_stage #(.RCON(RCON[i])) u_key (
                .clk       (clk),
                .en        (advance),
                .key_in    (key_q[i]),
                .key_next  (key_q[i+1]),
                .round_key (round_key[i])
            );
        end
        else
        begin : g_last
            // nothing follows the last key, so its registered copy stays open
            aes_key_stage #(.RCON(RCON[i])) u_key (
                .clk       (clk),
                .en        (advance),
                .key_in    (key_q[i]),
                .key_next  (),
                .round_key (round_key[i])
            );
        end
    end

    ////////////////////////////////////////
    // round chain
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROUNDS - 1; i++)
    begin : g_round
        aes_round u_round (
            .clk       (clk),
            .en        (advance),
            .state_in  (state_q[i]),
            .round_key (round_key[i]),
            .state_out (state_q[i+1])
        );
    end

    aes_final_round u_final (
        .clk       (clk),
        .en        (advance),
        .state_in  (state_q[NUM_ROUNDS-1]),
        .round_key (round_key[NUM_ROUNDS-1]),
        .state_out (ciphertext)
    );

endmodule

/* tests/aes128_asserts.sv */
`timescale 1ns/10ps

module aes128_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            in_ready,
    input logic            out_valid,
    input logic            out_ready,
    input aes_pkg::block_t ciphertext
);

    // a stalled output block must not change
    hold_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(ciphertext))
    else $error("ciphertext changed while the output was stalled");

    ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (!out_valid || out_ready))
    else $error("in_ready does not follow out_valid and out_ready");

    reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind aes128_core aes128_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .ciphertext (ciphertext)
);

/* tests/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// multiply by x modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ x;
        x = xtime(x);
    end
    return p;
endfunction

// a^254 is the inverse and leaves 0 at 0
function automatic logic [7:0] field_inverse(input logic [7:0] a);
    logic [7:0] r;
    logic [7:0] sq;
    r = 8'h01;
    sq = a;
    for (int i = 0; i < 8; i++)
    begin
        if (i != 0)
            r = field_mul(r, sq);
        sq = field_mul(sq, sq);
    end
    return r;
endfunction

function automatic logic [7:0] sub_byte(input logic [7:0] a);
    logic [7:0] b;
    b = field_inverse(a);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

function automatic logic [127:0] expand_key_step(input logic [127:0] k, input logic [7:0] rc);
    logic [31:0] w [4];
    logic [31:0] t;
    for (int i = 0; i < 4; i++)
        w[i] = k[127 - 32 * i -: 32];
    // RotWord then SubWord on the last word
    t = {sub_byte(k[23:16]) ^ rc, sub_byte(k[15:8]), sub_byte(k[7:0]), sub_byte(k[31:24])};
    w[0] = w[0] ^ t;
    w[1] = w[1] ^ w[0];
    w[2] = w[2] ^ w[1];
    w[3] = w[3] ^ w[2];
    return {w[0], w[1], w[2], w[3]};
endfunction

function automatic logic [127:0] aes_encrypt(input logic [127:0] pt, input logic [127:0] k);
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [127:0] rk;
    logic [7:0]   rc;
    logic [127:0] out;
    rk = k;
    rc = 8'h01;
    for (int n = 0; n < 16; n++)
        s[n] = pt[127 - 8 * n -: 8] ^ k[127 - 8 * n -: 8];
    for (int round = 1; round <= 10; round++)
    begin
        // row r of column c comes from column c + r
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                t[4 * c + r] = sub_byte(s[4 * ((c + r) % 4) + r]);
        for (int c = 0; c < 4; c++)
        begin
            if (round < 10)
            begin
                s[4 * c]     = xtime(t[4 * c]) ^ xtime(t[4 * c + 1]) ^ t[4 * c + 1]
                               ^ t[4 * c + 2] ^ t[4 * c + 3];
                s[4 * c + 1] = t[4 * c] ^ xtime(t[4 * c + 1]) ^ xtime(t[4 * c + 2])
                               ^ t[4 * c + 2] ^ t[4 * c + 3];
                s[4 * c + 2] = t[4 * c] ^ t[4 * c + 1] ^ xtime(t[4 * c + 2])
                               ^ xtime(t[4 * c + 3]) ^ t[4 * c + 3];
                s[4 * c + 3] = xtime(t[4 * c]) ^ t[4 * c] ^ t[4 * c + 1] ^ t[4 * c + 2]
                               ^ xtime(t[4 * c + 3]);
            end
            else
            begin
                for (int r = 0; r < 4; r++)
                    s[4 * c + r] = t[4 * c + r];
            end
        end
        rk = expand_key_step(rk, rc);
        rc = xtime(rc);
        for (int n = 0; n < 16; n++)
            s[n] = s[n] ^ rk[127 - 8 * n -: 8];
    end
    for (int n = 0; n < 16; n++)
        out[127 - 8 * n -: 8] = s[n];
    return out;
endfunction

`endif

/* tests/aes128_tb.sv */
`timescale 1ns/10ps

module aes128_tb;

    import aes_pkg::*;

    `include "aes_ref_model.svh"

    localparam logic [31:0] LFSR_SEED    = 32'h735a_dfc1;
    localparam int          NUM_BLOCKS   = 200;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          STREAM_LIMIT = 10000;

    localparam block_t KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    block_t plaintext;
    block_t key;
    logic   out_valid;
    logic   out_ready;
    block_t ciphertext;

    logic [31:0] lfsr_q;
    block_t      expected_q [$];
    block_t      expected;
    int          checks;
    int          errors;
    int          test_errors;

    aes128_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[126:0], lfsr_q[0]};
        end
    endtask

    task automatic send_single(input block_t pt, input block_t k, input block_t ct,
                               output int latency);
        int cycles;
        in_valid  <= 1'b1;
        plaintext <= pt;
        key       <= k;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!in_ready && cycles < WAIT_LIMIT);
        in_valid <= 1'b0;
        assert (in_ready)
        else
        begin
            $display("timeout: the core never accepted the block");
            errors++;
        end
        if (in_ready)
            expected_q.push_back(ct);
        latency = 0;
        do
        begin
            @(posedge clk);
            latency++;
        end
        while (!out_valid && latency < WAIT_LIMIT);
        assert (out_valid)
        else
        begin
            $display("timeout: no output block after the single input");
            errors++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (expected_q.size() == 0)
        else
        begin
            $display("timeout: %0d blocks never came out", expected_q.size());
            errors++;
        end
    endtask

    // with gaps set, valid and out_ready each follow one random bit per cycle
    task automatic run_stream(input int count, input bit gaps);
        logic [127:0] r;
        int           sent;
        int           cycles;
        sent = 0;
        cycles = 0;
        random_bits(128, r);
        plaintext <= r;
        random_bits(128, r);
        key       <= r;
        in_valid  <= 1'b1;
        out_ready <= 1'b1;
        while (sent < count && cycles < STREAM_LIMIT)
        begin
            @(posedge clk);
            cycles++;
            if (in_valid && in_ready)
            begin
                expected_q.push_back(aes_encrypt(plaintext, key));
                sent++;
                random_bits(128, r);
                plaintext <= r;
                random_bits(128, r);
                key <= r;
            end
            if (gaps)
            begin
                // a pending block stays valid until it is taken
                if (!in_valid || in_ready)
                begin
                    random_bits(1, r);
                    in_valid <= r[0];
                end
                random_bits(1, r);
                out_ready <= r[0];
            end
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        assert (sent == count)
        else
        begin
            $display("timeout: only %0d of %0d blocks were accepted", sent, count);
            errors++;
        end
        wait_drain();
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // output comparison
    ////////////////////////////////////////

    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            assert (expected_q.size() > 0)
            else
            begin
                $display("output block at %0t with no block outstanding", $time);
                errors++;
            end
            if (expected_q.size() > 0)
            begin
                expected = expected_q.pop_front();
                checks++;
                assert (ciphertext === expected)
                else
                begin
                    $display("Fail at %0t: ciphertext %h, expected %h",
                             $time, ciphertext, expected);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        logic [127:0] r;
        block_t       pt;
        block_t       k;
        int           latency;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        plaintext = '0;
        key = '0;
        lfsr_q = LFSR_SEED;
        checks = 0;
        errors = 0;
        test_errors = 0;

        // out_ready stays low here so in_ready reflects out_valid alone
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        checks += 2;
        assert (out_valid === 1'b0)
        else
        begin
            $display("Fail at %0t: out_valid is %b after reset", $time, out_valid);
            errors++;
        end
        assert (in_ready === 1'b1)
        else
        begin
            $display("Fail at %0t: in_ready is %b after reset", $time, in_ready);
            errors++;
        end
        report_test("reset state");
        out_ready <= 1'b1;

        checks++;
        assert (aes_encrypt(KAT_PT, KAT_KEY) === KAT_CT)
        else
        begin
            $display("Fail at %0t: reference gives %h for the known answer",
                     $time, aes_encrypt(KAT_PT, KAT_KEY));
            errors++;
        end
        send_single(KAT_PT, KAT_KEY, KAT_CT, latency);
        wait_drain();
        report_test("known answer");

        random_bits(128, r);
        pt = r;
        random_bits(128, r);
        k = r;
        send_single(pt, k, aes_encrypt(pt, k), latency);
        checks++;
        assert (latency == PIPE_LATENCY)
        else
        begin
            $display("Fail at %0t: latency %0d cycles, expected %0d",
                     $time, latency, PIPE_LATENCY);
            errors++;
        end
        wait_drain();
        report_test("latency");

        run_stream(NUM_BLOCKS, 1'b0);
        report_test("full throughput");

        run_stream(NUM_BLOCKS, 1'b1);
        report_test("back-pressure and bubbles");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+tests
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_column_lookup.sv
design/aes_key_stage.sv
design/aes_round.sv
design/aes_final_round.sv
design/aes128_core.sv
tests/aes128_asserts.sv
tests/aes128_tb.sv
